// File: hw/dma_pkg.sv
// DMA package with bus widths, address and length types, burst and beat descriptors
package dma_pkg;

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------
    localparam int unsigned DataWidth   = 32;
    localparam int unsigned StrbWidth   = DataWidth / 8;
    localparam int unsigned OffsetWidth = $clog2(StrbWidth);
    localparam int unsigned AddrWidth   = 16;
    localparam int unsigned LenWidth    = 16;
    // Aligner byte queue holds two words
    localparam int unsigned QueueBytes  = 2 * StrbWidth;

    // --------------------------------------------------
    // Basic types
    // --------------------------------------------------
    typedef logic [AddrWidth-1:0]          addr_t;
    typedef logic [LenWidth-1:0]           len_t;
    typedef logic [DataWidth-1:0]          data_t;
    typedef logic [StrbWidth-1:0]          strb_t;
    typedef logic [OffsetWidth-1:0]        offset_t;
    // Bytes in one burst, 1 to StrbWidth
    typedef logic [OffsetWidth:0]          beat_len_t;
    // Fill level of the aligner queue, 0 to QueueBytes
    typedef logic [$clog2(QueueBytes):0]   fill_t;

    // --------------------------------------------------
    // Descriptors
    // --------------------------------------------------
    // Read burst, word address plus first byte and byte count
    typedef struct packed {
        addr_t     addr;
        offset_t   offset;
        beat_len_t len;
    } rd_burst_t;

    // Write burst, last marks the final burst of a transfer
    typedef struct packed {
        addr_t     addr;
        offset_t   offset;
        beat_len_t len;
        logic      last;
    } wr_burst_t;

    // Returned read word with the bytes it carries
    typedef struct packed {
        data_t     data;
        offset_t   offset;
        beat_len_t len;
    } rd_beat_t;

endpackage

// File: hw/dma_stream_fifo.sv
// Two-entry valid/ready stream FIFO with a type-parameterized payload
module dma_stream_fifo #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     arst_n_i,
    // Push side
    input  logic     push_valid_i,
    output logic     push_ready_o,
    input  payload_t push_data_i,
    // Pop side
    output logic     pop_valid_o,
    input  logic     pop_ready_i,
    output payload_t pop_data_o
);

    // Storage, no reset needed
    payload_t   mem_q [2];
    logic       wr_ptr_q;
    logic       rd_ptr_q;
    // Entries held, 0 to 2
    logic [1:0] count_q;
    logic       push;
    logic       pop;

    assign push_ready_o = (count_q != 2'd2);
    assign pop_valid_o  = (count_q != 2'd0);
    assign pop_data_o   = mem_q[rd_ptr_q];
    assign push         = push_valid_i & push_ready_o;
    assign pop          = pop_valid_o & pop_ready_i;

    // Pointers and fill count
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            count_q  <= 2'd0;
        end else begin
            if (push) wr_ptr_q <= ~wr_ptr_q;
            if (pop)  rd_ptr_q <= ~rd_ptr_q;
            count_q <= count_q + {1'b0, push} - {1'b0, pop};
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    // A push held off by a full FIFO waits with its payload unchanged
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (push_valid_i && !push_ready_o) |=> (push_valid_i && $stable(push_data_i)));

endmodule

// File: hw/dma_legalizer.sv
// Legalizer splitting a 1D transfer into word-bounded read and write bursts
module dma_legalizer import dma_pkg::*; (
    input  logic      clk_i,
    input  logic      arst_n_i,
    // Transfer request
    input  addr_t     req_src_addr_i,
    input  addr_t     req_dst_addr_i,
    input  len_t      req_length_i,
    input  logic      req_valid_i,
    output logic      req_ready_o,
    // Read bursts
    output logic      rd_valid_o,
    input  logic      rd_ready_i,
    output rd_burst_t rd_burst_o,
    // Write bursts
    output logic      wr_valid_o,
    input  logic      wr_ready_i,
    output wr_burst_t wr_burst_o,
    // Completion from the writer
    input  logic      done_i,
    output logic      busy_o
);

    // Bytes up to the next word boundary, capped by what remains
    function automatic beat_len_t burst_bytes(input addr_t addr, input len_t len);
        beat_len_t to_bound;
        to_bound = beat_len_t'(StrbWidth) - beat_len_t'(addr[OffsetWidth-1:0]);
        if (len < len_t'(to_bound)) begin
            return beat_len_t'(len);
        end
        return to_bound;
    endfunction

    // Read and write machine state
    addr_t     r_addr_q;
    addr_t     w_addr_q;
    len_t      r_len_q;
    len_t      w_len_q;
    logic      r_busy_q;
    logic      w_busy_q;
    // Whole transfer state
    logic      busy_q;
    logic      ready_q;

    beat_len_t r_num;
    beat_len_t w_num;
    logic      r_last;
    logic      w_last;
    logic      r_step;
    logic      w_step;
    logic      accept;

    // New request only with both machines idle
    assign req_ready_o = ready_q & ~r_busy_q & ~w_busy_q;
    assign accept      = req_valid_i & req_ready_o;
    assign busy_o      = busy_q;

    // --------------------------------------------------
    // Burst sizing
    // --------------------------------------------------
    assign r_num  = burst_bytes(r_addr_q, r_len_q);
    assign w_num  = burst_bytes(w_addr_q, w_len_q);
    // Final burst when it covers the remainder
    assign r_last = (r_len_q == len_t'(r_num));
    assign w_last = (w_len_q == len_t'(w_num));
    assign r_step = rd_valid_o & rd_ready_i;
    assign w_step = wr_valid_o & wr_ready_i;

    // --------------------------------------------------
    // Burst outputs
    // --------------------------------------------------
    assign rd_valid_o = r_busy_q;
    assign wr_valid_o = w_busy_q;

    assign rd_burst_o = '{
        addr:   {r_addr_q[AddrWidth-1:OffsetWidth], {OffsetWidth{1'b0}}},
        offset: r_addr_q[OffsetWidth-1:0],
        len:    r_num
    };

    assign wr_burst_o = '{
        addr:   {w_addr_q[AddrWidth-1:OffsetWidth], {OffsetWidth{1'b0}}},
        offset: w_addr_q[OffsetWidth-1:0],
        len:    w_num,
        last:   w_last
    };

    // --------------------------------------------------
    // State
    // --------------------------------------------------
    // Machines run decoupled, each stalls on its own FIFO
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            r_busy_q <= 1'b0;
            w_busy_q <= 1'b0;
        end else if (accept) begin
            r_busy_q <= 1'b1;
            w_busy_q <= 1'b1;
        end else begin
            if (r_step && r_last) r_busy_q <= 1'b0;
            if (w_step && w_last) w_busy_q <= 1'b0;
        end
    end

    // Address and remaining length, loaded on accept
    always_ff @(posedge clk_i) begin
        if (accept) begin
            r_addr_q <= req_src_addr_i;
            w_addr_q <= req_dst_addr_i;
            r_len_q  <= req_length_i;
            w_len_q  <= req_length_i;
        end else begin
            if (r_step) begin
                r_addr_q <= r_addr_q + addr_t'(r_num);
                r_len_q  <= r_len_q - len_t'(r_num);
            end
            if (w_step) begin
                w_addr_q <= w_addr_q + addr_t'(w_num);
                w_len_q  <= w_len_q - len_t'(w_num);
            end
        end
    end

    // Busy until the writer finishes, ready low during reset
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q  <= 1'b0;
            ready_q <= 1'b0;
        end else if (accept) begin
            busy_q  <= 1'b1;
            ready_q <= 1'b0;
        end else if (done_i) begin
            busy_q  <= 1'b0;
            ready_q <= 1'b1;
        end else if (!busy_q) begin
            ready_q <= 1'b1;
        end
    end

    // Zero-length transfers are illegal
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        accept |-> (req_length_i != '0));

endmodule

// File: hw/dma_obi_reader.sv
// OBI read master pairing returned words with their burst metadata
module dma_obi_reader import dma_pkg::*; (
    input  logic      clk_i,
    input  logic      arst_n_i,
    // Read bursts from the legalizer
    input  logic      burst_valid_i,
    output logic      burst_ready_o,
    input  rd_burst_t burst_i,
    // OBI read port
    output logic      rd_req_o,
    output addr_t     rd_addr_o,
    input  logic      rd_gnt_i,
    input  logic      rd_rvalid_i,
    input  data_t     rd_rdata_i,
    // Read beats to the aligner
    output logic      beat_valid_o,
    input  logic      beat_ready_i,
    output rd_beat_t  beat_o
);

    logic      meta_ready;
    logic      meta_valid;
    rd_burst_t meta_head;
    logic      beat_fire;

    // Returned words waiting for the aligner
    data_t      data_q [2];
    logic       data_wr_q;
    logic       data_rd_q;
    logic [1:0] data_cnt_q;

    // --------------------------------------------------
    // Request side
    // --------------------------------------------------
    // Issue only with room for the metadata
    assign rd_req_o      = burst_valid_i & meta_ready;
    assign rd_addr_o     = burst_i.addr;
    assign burst_ready_o = meta_ready & rd_gnt_i;

    // Metadata lives until its beat is consumed
    dma_stream_fifo #(
        .payload_t (rd_burst_t)
    ) i_meta_fifo (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .push_valid_i (rd_req_o & rd_gnt_i),
        .push_ready_o (meta_ready),
        .push_data_i  (burst_i),
        .pop_valid_o  (meta_valid),
        .pop_ready_i  (beat_fire),
        .pop_data_o   (meta_head)
    );

    // --------------------------------------------------
    // Response side
    // --------------------------------------------------
    assign beat_valid_o = (data_cnt_q != 2'd0);
    assign beat_fire    = beat_valid_o & beat_ready_i;
    // Head word pairs with head metadata, both in order
    assign beat_o = '{data: data_q[data_rd_q], offset: meta_head.offset, len: meta_head.len};

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            data_wr_q  <= 1'b0;
            data_rd_q  <= 1'b0;
            data_cnt_q <= 2'd0;
        end else begin
            if (rd_rvalid_i) data_wr_q <= ~data_wr_q;
            if (beat_fire)   data_rd_q <= ~data_rd_q;
            data_cnt_q <= data_cnt_q + {1'b0, rd_rvalid_i} - {1'b0, beat_fire};
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_rvalid_i) begin
            data_q[data_wr_q] <= rd_rdata_i;
        end
    end

    // Every response belongs to a granted read still on record
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        rd_rvalid_i |-> (meta_valid && data_cnt_q != 2'd2));

endmodule

// File: hw/dma_byte_aligner.sv
// Byte queue realigning read beats into write words with strobes
module dma_byte_aligner import dma_pkg::*; (
    input  logic      clk_i,
    input  logic      arst_n_i,
    // Read beats
    input  logic      beat_valid_i,
    output logic      beat_ready_o,
    input  rd_beat_t  beat_i,
    // Write bursts
    input  logic      burst_valid_i,
    output logic      burst_ready_o,
    input  wr_burst_t burst_i,
    // Write words to the writer
    output logic      wr_valid_o,
    input  logic      wr_ready_i,
    output addr_t     wr_addr_o,
    output data_t     wr_data_o,
    output strb_t     wr_strb_o,
    output logic      wr_last_o
);

    // Byte 0 is the queue head
    logic [7:0] q_q [QueueBytes];
    logic [7:0] q_d [QueueBytes];
    fill_t      fill_q;
    fill_t      fill_d;
    fill_t      base;
    logic       take;
    logic       emit;

    // Beat only when all its bytes fit
    assign beat_ready_o = (fill_q + fill_t'(beat_i.len)) <= fill_t'(QueueBytes);
    assign take         = beat_valid_i & beat_ready_o;

    // Word ready once the queue holds the burst's bytes
    assign wr_valid_o    = burst_valid_i & (fill_q >= fill_t'(burst_i.len));
    assign emit          = wr_valid_o & wr_ready_i;
    assign burst_ready_o = emit;
    assign wr_addr_o     = burst_i.addr;
    assign wr_last_o     = burst_i.last;

    // --------------------------------------------------
    // Queue update
    // --------------------------------------------------
    always_comb begin
        q_d  = q_q;
        base = fill_q;
        // Drop the emitted bytes from the head
        if (emit) begin
            for (int j = 0; j < QueueBytes; j++) begin
                if (j + int'(burst_i.len) < QueueBytes) begin
                    q_d[j] = q_q[j + int'(burst_i.len)];
                end
            end
            base = fill_q - fill_t'(burst_i.len);
        end
        fill_d = base;
        // Append beat bytes starting at its offset
        if (take) begin
            for (int j = 0; j < QueueBytes; j++) begin
                if (j >= int'(base) && j < int'(base) + int'(beat_i.len)) begin
                    q_d[j] = beat_i.data[8 * (j - int'(base) + int'(beat_i.offset)) +: 8];
                end
            end
            fill_d = base + fill_t'(beat_i.len);
        end
    end

    // --------------------------------------------------
    // Output word
    // --------------------------------------------------
    // Head bytes land at the burst offset
    always_comb begin
        wr_data_o = '0;
        wr_strb_o = '0;
        for (int k = 0; k < StrbWidth; k++) begin
            if (k >= int'(burst_i.offset) && k < int'(burst_i.offset) + int'(burst_i.len)) begin
                wr_data_o[8*k +: 8] = q_q[k - int'(burst_i.offset)];
                wr_strb_o[k]        = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fill_q <= '0;
        end else begin
            fill_q <= fill_d;
        end
    end

    always_ff @(posedge clk_i) begin
        q_q <= q_d;
    end

    // Legalized bursts always carry at least one byte
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        emit |-> (wr_strb_o != '0));

endmodule

// File: hw/dma_obi_writer.sv
// OBI write master with a registered request stage and completion pulse
module dma_obi_writer import dma_pkg::*; (
    input  logic  clk_i,
    input  logic  arst_n_i,
    // Write words from the aligner
    input  logic  wr_valid_i,
    output logic  wr_ready_o,
    input  addr_t wr_addr_i,
    input  data_t wr_data_i,
    input  strb_t wr_strb_i,
    input  logic  wr_last_i,
    // OBI write port
    output logic  wr_req_o,
    output addr_t wr_addr_o,
    output data_t wr_wdata_o,
    output strb_t wr_be_o,
    input  logic  wr_gnt_i,
    // Transfer finished
    output logic  done_o
);

    logic  req_q;
    logic  last_q;
    addr_t addr_q;
    data_t data_q;
    strb_t be_q;

    // Stage frees up on grant
    assign wr_ready_o = ~req_q | wr_gnt_i;
    assign wr_req_o   = req_q;
    assign wr_addr_o  = addr_q;
    assign wr_wdata_o = data_q;
    assign wr_be_o    = be_q;
    // One pulse, on the grant of the last write
    assign done_o     = req_q & wr_gnt_i & last_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            req_q <= 1'b0;
        end else if (wr_ready_o) begin
            req_q <= wr_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_valid_i && wr_ready_o) begin
            addr_q <= wr_addr_i;
            data_q <= wr_data_i;
            be_q   <= wr_strb_i;
            last_q <= wr_last_i;
        end
    end

    // A stalled word keeps its address and data until the stage takes it
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (wr_valid_i && !wr_ready_o) |=>
            (wr_valid_i && $stable(wr_addr_i) && $stable(wr_data_i)));

endmodule

// File: hw/dma_top.sv
// DMA top level wiring legalizer, burst FIFOs, reader, aligner and writer
module dma_top import dma_pkg::*; (
    input  logic  clk_i,
    input  logic  arst_n_i,
    // Transfer request
    input  addr_t req_src_addr_i,
    input  addr_t req_dst_addr_i,
    input  len_t  req_length_i,
    input  logic  req_valid_i,
    output logic  req_ready_o,
    output logic  busy_o,
    output logic  done_o,
    // OBI read port
    output logic  rd_req_o,
    output addr_t rd_addr_o,
    input  logic  rd_gnt_i,
    input  logic  rd_rvalid_i,
    input  data_t rd_rdata_i,
    // OBI write port
    output logic  wr_req_o,
    output addr_t wr_addr_o,
    output data_t wr_wdata_o,
    output strb_t wr_be_o,
    input  logic  wr_gnt_i
);

    // Legalizer to FIFOs
    logic      lg_rd_valid, lg_rd_ready, lg_wr_valid, lg_wr_ready;
    rd_burst_t lg_rd_burst;
    wr_burst_t lg_wr_burst;
    // FIFOs to reader and aligner
    logic      rf_valid, rf_ready, wf_valid, wf_ready;
    rd_burst_t rf_burst;
    wr_burst_t wf_burst;
    // Reader to aligner
    logic      beat_valid, beat_ready;
    rd_beat_t  beat;
    // Aligner to writer
    logic      al_valid, al_ready, al_last;
    addr_t     al_addr;
    data_t     al_data;
    strb_t     al_strb;

    dma_legalizer i_legalizer (
        .clk_i, .arst_n_i,
        .req_src_addr_i, .req_dst_addr_i, .req_length_i, .req_valid_i, .req_ready_o,
        .rd_valid_o (lg_rd_valid), .rd_ready_i (lg_rd_ready), .rd_burst_o (lg_rd_burst),
        .wr_valid_o (lg_wr_valid), .wr_ready_i (lg_wr_ready), .wr_burst_o (lg_wr_burst),
        .done_i     (done_o),      .busy_o
    );

    dma_stream_fifo #(.payload_t(rd_burst_t)) i_rd_fifo (
        .clk_i, .arst_n_i,
        .push_valid_i (lg_rd_valid), .push_ready_o (lg_rd_ready), .push_data_i (lg_rd_burst),
        .pop_valid_o  (rf_valid),    .pop_ready_i  (rf_ready),    .pop_data_o  (rf_burst)
    );

    dma_stream_fifo #(.payload_t(wr_burst_t)) i_wr_fifo (
        .clk_i, .arst_n_i,
        .push_valid_i (lg_wr_valid), .push_ready_o (lg_wr_ready), .push_data_i (lg_wr_burst),
        .pop_valid_o  (wf_valid),    .pop_ready_i  (wf_ready),    .pop_data_o  (wf_burst)
    );

    dma_obi_reader i_reader (
        .clk_i, .arst_n_i,
        .burst_valid_i (rf_valid), .burst_ready_o (rf_ready), .burst_i (rf_burst),
        .rd_req_o, .rd_addr_o, .rd_gnt_i, .rd_rvalid_i, .rd_rdata_i,
        .beat_valid_o  (beat_valid), .beat_ready_i (beat_ready), .beat_o (beat)
    );

    dma_byte_aligner i_aligner (
        .clk_i, .arst_n_i,
        .beat_valid_i  (beat_valid), .beat_ready_o  (beat_ready), .beat_i  (beat),
        .burst_valid_i (wf_valid),   .burst_ready_o (wf_ready),   .burst_i (wf_burst),
        .wr_valid_o    (al_valid),   .wr_ready_i    (al_ready),
        .wr_addr_o     (al_addr),    .wr_data_o     (al_data),
        .wr_strb_o     (al_strb),    .wr_last_o     (al_last)
    );

    dma_obi_writer i_writer (
        .clk_i, .arst_n_i,
        .wr_valid_i (al_valid), .wr_ready_o (al_ready),
        .wr_addr_i  (al_addr),  .wr_data_i  (al_data),
        .wr_strb_i  (al_strb),  .wr_last_i  (al_last),
        .wr_req_o, .wr_addr_o, .wr_wdata_o, .wr_be_o, .wr_gnt_i,
        .done_o
    );

endmodule

// File: verif/tb_obi_mem.sv
// OBI memory model serving one read port and one write port with random delays
module tb_obi_mem import dma_pkg::*; (
    input  logic  clk_i,
    input  logic  arst_n_i,
    // OBI read port
    input  logic  rd_req_i,
    input  addr_t rd_addr_i,
    output logic  rd_gnt_o,
    output logic  rd_rvalid_o,
    output data_t rd_rdata_o,
    // OBI write port
    input  logic  wr_req_i,
    input  addr_t wr_addr_i,
    input  data_t wr_wdata_i,
    input  strb_t wr_be_i,
    output logic  wr_gnt_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // 64 KiB of bytes, loaded by the testbench
    logic [7:0] mem [65536];
    // Granted reads waiting for their response
    data_t      rsp_data [$];
    int         rsp_wait [$];
    int         rd_wait;
    int         wr_wait;

    // Little endian, byte k of the word sits at addr + k
    function automatic data_t read_word(input addr_t addr);
        data_t word;
        for (int k = 0; k < StrbWidth; k++) begin
            word[8*k +: 8] = mem[addr_t'(addr + k)];
        end
        return word;
    endfunction

    // --------------------------------------------------
    // Port handling, outputs change on the falling edge
    // --------------------------------------------------
    initial begin
        rd_gnt_o    = 1'b0;
        rd_rvalid_o = 1'b0;
        rd_rdata_o  = '0;
        wr_gnt_o    = 1'b0;
        rd_wait     = 0;
        wr_wait     = 0;
        forever begin
            @(negedge clk_i);
            if (!arst_n_i) begin
                rsp_data.delete();
                rsp_wait.delete();
                rd_gnt_o    = 1'b0;
                rd_rvalid_o = 1'b0;
                wr_gnt_o    = 1'b0;
            end else begin
                // Responses in grant order, earliest one cycle after grant
                rd_rvalid_o = 1'b0;
                if (rsp_data.size() > 0) begin
                    if (rsp_wait[0] == 0) begin
                        rd_rvalid_o = 1'b1;
                        rd_rdata_o  = rsp_data.pop_front();
                        void'(rsp_wait.pop_front());
                    end else begin
                        rsp_wait[0] = rsp_wait[0] - 1;
                    end
                end
                // Read grant after a random wait
                rd_gnt_o = 1'b0;
                if (rd_req_i) begin
                    if (rd_wait == 0) begin
                        rd_gnt_o = 1'b1;
                        rsp_data.push_back(read_word(rd_addr_i));
                        rsp_wait.push_back(int'($urandom_range(3, 0)));
                        rd_wait = int'($urandom_range(3, 0));
                    end else begin
                        rd_wait = rd_wait - 1;
                    end
                end
                // Write grant, enabled bytes land at once
                wr_gnt_o = 1'b0;
                if (wr_req_i) begin
                    if (wr_wait == 0) begin
                        wr_gnt_o = 1'b1;
                        for (int k = 0; k < StrbWidth; k++) begin
                            if (wr_be_i[k]) begin
                                mem[addr_t'(wr_addr_i + k)] = wr_wdata_i[8*k +: 8];
                            end
                        end
                        wr_wait = int'($urandom_range(3, 0));
                    end else begin
                        wr_wait = wr_wait - 1;
                    end
                end
            end
        end
    end

endmodule

// File: verif/tb_dma_top.sv
// Testbench top for the DMA with clock, reset, stimulus table and memory checks
module tb_dma_top import dma_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NumRows      = 8;
    localparam int ReadyTimeout = 100;
    localparam int DoneTimeout  = 5000;

    logic  clk;
    logic  arst_n;
    addr_t req_src_addr;
    addr_t req_dst_addr;
    len_t  req_length;
    logic  req_valid;
    logic  req_ready;
    logic  busy;
    logic  done;
    logic  rd_req;
    addr_t rd_addr;
    logic  rd_gnt;
    logic  rd_rvalid;
    data_t rd_rdata;
    logic  wr_req;
    addr_t wr_addr;
    data_t wr_wdata;
    strb_t wr_be;
    logic  wr_gnt;

    // Memory image taken before each row
    logic [7:0] saved [65536];
    int         done_count = 0;

    // --------------------------------------------------
    // Stimulus table
    // --------------------------------------------------
    string test_name [NumRows] = '{"aligned_16", "src_offset1_13", "dst_offset3_13",
        "single_byte", "two_bytes", "long_200", "back_to_back_a", "back_to_back_b"};
    addr_t test_src [NumRows] = '{16'h1000, 16'h1101, 16'h1200, 16'h1301,
        16'h1402, 16'h1503, 16'h3001, 16'h3100};
    addr_t test_dst [NumRows] = '{16'h2000, 16'h2100, 16'h2203, 16'h2302,
        16'h2401, 16'h2601, 16'h4002, 16'h4103};
    len_t  test_len [NumRows] = '{16'd16, 16'd13, 16'd13, 16'd1, 16'd2, 16'd200, 16'd37, 16'd22};

    dma_top uut (
        .clk_i (clk), .arst_n_i (arst_n),
        .req_src_addr_i (req_src_addr), .req_dst_addr_i (req_dst_addr),
        .req_length_i (req_length), .req_valid_i (req_valid), .req_ready_o (req_ready),
        .busy_o (busy), .done_o (done),
        .rd_req_o (rd_req), .rd_addr_o (rd_addr), .rd_gnt_i (rd_gnt),
        .rd_rvalid_i (rd_rvalid), .rd_rdata_i (rd_rdata),
        .wr_req_o (wr_req), .wr_addr_o (wr_addr), .wr_wdata_o (wr_wdata),
        .wr_be_o (wr_be), .wr_gnt_i (wr_gnt)
    );

    tb_obi_mem mem_model (
        .clk_i (clk), .arst_n_i (arst_n),
        .rd_req_i (rd_req), .rd_addr_i (rd_addr), .rd_gnt_o (rd_gnt),
        .rd_rvalid_o (rd_rvalid), .rd_rdata_o (rd_rdata),
        .wr_req_i (wr_req), .wr_addr_i (wr_addr), .wr_wdata_i (wr_wdata),
        .wr_be_i (wr_be), .wr_gnt_o (wr_gnt)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("Some tests failed");
        $fatal(1);
    endtask

    // Done pulses, and no open request port during a transfer
    always @(posedge clk) begin
        if (arst_n) begin
            if (done) done_count = done_count + 1;
            assert (!(busy && req_ready)) else begin
                $display("req_ready_o was high while busy_o was high");
                stop_with_failure();
            end
        end
    end

    task automatic fill_memory();
        logic [7:0] b;
        for (int a = 0; a < 65536; a++) begin
            b = 8'($urandom);
            mem_model.mem[a] = b;
            saved[a] = b;
        end
    endtask

    task automatic wait_for_ready(input string name);
        int cycles;
        cycles = 0;
        while (!req_ready && cycles < ReadyTimeout) begin
            @(negedge clk);
            cycles++;
        end
        assert (req_ready) else begin
            $display("Timeout waiting for req_ready_o in test %s", name);
            stop_with_failure();
        end
    endtask

    task automatic check_done_count(input string name, input int expected);
        assert (done_count == expected) else begin
            $display("Fail %s done pulses expected %0d actual %0d", name, expected, done_count);
            stop_with_failure();
        end
    endtask

    // Destination holds the source copy, all else unchanged
    task automatic check_memory(input int row);
        int         src;
        int         dst;
        int         len;
        logic [7:0] expected;
        src = int'(test_src[row]);
        dst = int'(test_dst[row]);
        len = int'(test_len[row]);
        for (int a = 0; a < 65536; a++) begin
            if (a >= dst && a < dst + len) expected = saved[src + a - dst];
            else expected = saved[a];
            assert (mem_model.mem[a] == expected) else begin
                $display("Fail %s addr %h expected %h actual %h",
                         test_name[row], a[15:0], expected, mem_model.mem[a]);
                stop_with_failure();
            end
        end
    endtask

    task automatic run_row(input int row);
        int cycles;
        check_done_count(test_name[row], row);
        fill_memory();
        // Valid goes up at once, acceptance waits for the port
        req_src_addr = test_src[row];
        req_dst_addr = test_dst[row];
        req_length   = test_len[row];
        req_valid    = 1'b1;
        wait_for_ready(test_name[row]);
        @(negedge clk);
        req_valid = 1'b0;
        assert (busy) else begin
            $display("busy_o stayed low after the request of test %s", test_name[row]);
            stop_with_failure();
        end
        cycles = 0;
        while (done_count < row + 1 && cycles < DoneTimeout) begin
            @(negedge clk);
            cycles++;
        end
        assert (done_count >= row + 1) else begin
            $display("Timeout waiting for done_o in test %s", test_name[row]);
            stop_with_failure();
        end
        check_memory(row);
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        void'($urandom(32'h22b4));
        arst_n       = 1'b0;
        req_src_addr = '0;
        req_dst_addr = '0;
        req_length   = '0;
        req_valid    = 1'b0;
        repeat (8) @(negedge clk);
        // Everything quiet in reset, request port closed
        assert (!req_ready && !busy && !done && !rd_req && !wr_req) else begin
            $display("Outputs not low during reset");
            stop_with_failure();
        end
        arst_n = 1'b1;
        @(negedge clk);
        assert (!busy && !done && !rd_req && !wr_req) else begin
            $display("Outputs not low right after reset");
            stop_with_failure();
        end
        for (int i = 0; i < NumRows; i++) begin
            run_row(i);
        end
        wait_for_ready("final");
        check_done_count("final", NumRows);
        $display("All tests passed");
        $finish;
    end

endmodule

// File: compile.f
hw/dma_pkg.sv
hw/dma_stream_fifo.sv
hw/dma_legalizer.sv
hw/dma_obi_reader.sv
hw/dma_byte_aligner.sv
hw/dma_obi_writer.sv
hw/dma_top.sv
verif/tb_obi_mem.sv
verif/tb_dma_top.sv
